/* bench/calc_ref.svh */
//////////////////////////////////////////////////
// Reference model for the back end testbench.
// Holds the ALU reference, the architectural
// register state and the register file model
// that supplies operands. Included in the bench.
//////////////////////////////////////////////////

`ifndef CALC_REF_SVH
`define CALC_REF_SVH

// Updated at dispatch, so it always holds the value a reader must see
data_t arch_rf [2**REG_ADDR_WIDTH];

// Written only when a write-back is due, three cycles late
data_t rf_model [2**REG_ADDR_WIDTH];

function automatic data_t ref_alu(input op_e op, input data_t a, input data_t b);
  logic [2*DATA_WIDTH-1:0] prod;
  prod = a;
  prod = prod * b;
  case (op)
    OP_ADD:   return a + b;
    OP_SUB:   return a - b;
    OP_AND:   return a & b;
    OP_OR:    return a | b;
    OP_XOR:   return a ^ b;
    OP_SLL:   return a << b[4:0];
    OP_SRL:   return a >> b[4:0];
    OP_SLT:   return ($signed(a) < $signed(b)) ? data_t'(1) : data_t'(0);
    OP_MUL:   return prod[DATA_WIDTH-1:0];
    OP_MULHU: return prod[2*DATA_WIDTH-1:DATA_WIDTH];
    default:  return '0;
  endcase
endfunction

function automatic void init_reg_files();
  for (int i = 0; i < 2**REG_ADDR_WIDTH; i++)
    begin
      arch_rf[i]  = $urandom();
      rf_model[i] = arch_rf[i];
    end
endfunction

function automatic reg_addr_t pick_reg(input int lo, input int hi);
  return reg_addr_t'($urandom_range(hi, lo));
endfunction

function automatic reg_addr_t pick_reg_except(input reg_addr_t skip, input int lo, input int hi);
  reg_addr_t r;
  r = skip;
  while (r == skip)
    r = pick_reg(lo, hi);
  return r;
endfunction

`endif

/* bench/tb_calc_top.sv */
//////////////////////////////////////////////////
// Testbench for the execution back end. Runs ALU,
// chain, multiply, injection and flush sequences
// with operands from a lagging register file and
// checks the write-back port every cycle.
//////////////////////////////////////////////////

module tb_calc_top
  import calc_pkg::*;
  ();

  localparam int RST_CYCLES  = 3;
  localparam int N_ALU       = 40;
  localparam int N_CHAIN     = 40;
  localparam int N_MUL       = 12;
  localparam int N_INJ       = 8;
  localparam int N_FLUSH     = 4;
  localparam int TEST_CYCLES = RST_CYCLES + 1 + N_ALU + N_CHAIN + 3*N_MUL
                               + 2*N_INJ + 6*N_FLUSH;
  localparam int MAX_CYCLES  = 2*TEST_CYCLES + 100;

  logic      clk;
  logic      rst;
  logic      dispatch_v;
  logic      dispatch_queue_v;
  op_e       dispatch_op;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  reg_addr_t rd_addr;
  logic      rd_w_v;
  data_t     rs1_data;
  data_t     rs2_data;
  logic      flush;
  logic      iwb_v;
  reg_addr_t iwb_rd_addr;
  data_t     iwb_data;

  int        cycle = 0;
  int        checks = 0;
  int        errors = 0;
  int        tests = 0;
  int        tests_failed = 0;
  int        test_err_start = 0;
  int        due_q [$];
  reg_addr_t rd_q [$];
  data_t     data_q [$];

  `include "calc_ref.svh"

  calc_top i_calc_top
    (.clk_i              (clk)
     ,.rst_i             (rst)
     ,.dispatch_v_i      (dispatch_v)
     ,.dispatch_queue_v_i(dispatch_queue_v)
     ,.dispatch_op_i     (dispatch_op)
     ,.rs1_addr_i        (rs1_addr)
     ,.rs2_addr_i        (rs2_addr)
     ,.rd_addr_i         (rd_addr)
     ,.rd_w_v_i          (rd_w_v)
     ,.rs1_data_i        (rs1_data)
     ,.rs2_data_i        (rs2_data)
     ,.flush_i           (flush)
     ,.iwb_v_o           (iwb_v)
     ,.iwb_rd_addr_o     (iwb_rd_addr)
     ,.iwb_data_o        (iwb_data)
     );

  initial
    begin
      clk = 1'b0;
      forever
        #5 clk = ~clk;
    end

  always @(posedge clk)
    begin
      cycle <= cycle + 1;
      if (cycle >= MAX_CYCLES)
        begin
          $display("Timeout: run did not finish within %0d cycles, %0d write-backs pending",
                   MAX_CYCLES, due_q.size());
          $display("*** FAILED ***");
          $finish;
        end
    end

  task automatic check_data(input data_t got, input data_t exp, input string what);
    checks++;
    if (got !== exp)
      begin
        errors++;
        $display("Error at %0t: %s data 0x%08h, expected 0x%08h", $time, what, got, exp);
      end
  endtask

  task automatic check_wb(input logic got_v, input reg_addr_t got_rd,
                          input logic exp_v, input reg_addr_t exp_rd);
    checks++;
    if (got_v !== exp_v || (exp_v && got_rd !== exp_rd))
      begin
        errors++;
        $display("Error at %0t: write-back valid %b rd %0d, expected valid %b rd %0d",
                 $time, got_v, got_rd, exp_v, exp_rd);
      end
  endtask

  // Each cycle carries the due write-back or nothing at all
  always @(negedge clk)
    begin
      if (cycle >= 1)
        begin
          if (due_q.size() != 0 && due_q[0] == cycle)
            begin
              check_wb(iwb_v, iwb_rd_addr, 1'b1, rd_q[0]);
              check_data(iwb_data, data_q[0], "write-back");
              rf_model[rd_q[0]] = data_q[0];
              void'(due_q.pop_front());
              void'(rd_q.pop_front());
              void'(data_q.pop_front());
            end
          else
            check_wb(iwb_v, iwb_rd_addr, 1'b0, '0);
        end
    end

  function automatic op_e rand_int_op();
    case ($urandom_range(7, 0))
      0:       return OP_ADD;
      1:       return OP_SUB;
      2:       return OP_AND;
      3:       return OP_OR;
      4:       return OP_XOR;
      5:       return OP_SLL;
      6:       return OP_SRL;
      default: return OP_SLT;
    endcase
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic expect_wb(input reg_addr_t rd, input data_t value);
    due_q.push_back(cycle + 3);
    rd_q.push_back(rd);
    data_q.push_back(value);
  endtask

  task automatic drive_idle();
    dispatch_v       = 1'b0;
    dispatch_queue_v = 1'b0;
    rd_w_v           = 1'b0;
    next_cycle();
  endtask

  // Operands from the lagging model, expectation from architectural state
  task automatic issue_op(input op_e op, input reg_addr_t rs1, input reg_addr_t rs2,
                          input reg_addr_t rd, input logic killed);
    data_t exp;
    dispatch_v       = 1'b1;
    dispatch_queue_v = 1'b1;
    dispatch_op      = op;
    rs1_addr         = rs1;
    rs2_addr         = rs2;
    rd_addr          = rd;
    rd_w_v           = 1'b1;
    rs1_data         = rf_model[rs1];
    rs2_data         = rf_model[rs2];
    exp = ref_alu(op, arch_rf[rs1], arch_rf[rs2]);
    if (!killed)
      begin
        arch_rf[rd] = exp;
        expect_wb(rd, exp);
      end
    next_cycle();
  endtask

  task automatic inject(input reg_addr_t rd, input data_t payload);
    dispatch_v       = 1'b1;
    dispatch_queue_v = 1'b0;
    rs1_addr         = '0;
    rd_addr          = rd;
    rd_w_v           = 1'b1;
    rs1_data         = $urandom();
    rs2_data         = payload;
    arch_rf[rd]      = payload;
    expect_wb(rd, payload);
    next_cycle();
  endtask

  task automatic finish_test(input string name);
    int n;
    while (due_q.size() != 0)
      drive_idle();
    drive_idle();
    n = errors - test_err_start;
    tests++;
    if (n != 0)
      tests_failed++;
    $display("Test %s finished with %0d errors", name, n);
    test_err_start = errors;
  endtask

  initial
    begin
      reg_addr_t   ra;
      reg_addr_t   rb;
      reg_addr_t   rc;
      reg_addr_t   re;
      reg_addr_t   prev;
      reg_addr_t   prev2;
      reg_addr_t   prev3;
      reg_addr_t   src2;
      reg_addr_t   dst;
      void'($urandom(3504));
      rst              = 1'b1;
      flush            = 1'b0;
      dispatch_v       = 1'b0;
      dispatch_queue_v = 1'b0;
      dispatch_op      = OP_ADD;
      rs1_addr         = '0;
      rs2_addr         = '0;
      rd_addr          = '0;
      rd_w_v           = 1'b0;
      rs1_data         = '0;
      rs2_data         = '0;
      init_reg_files();
      repeat (RST_CYCLES)
        @(posedge clk);
      #1;
      rst = 1'b0;

      // No write-back may show before the first dispatch completes
      issue_op(OP_ADD, pick_reg(16, 31), pick_reg(16, 31), pick_reg(0, 15), 1'b0);
      finish_test("reset");

      for (int i = 0; i < N_ALU; i++)
        issue_op(rand_int_op(), pick_reg(16, 31), pick_reg(16, 31), pick_reg(0, 15), 1'b0);
      finish_test("alu");

      // Sources hit stage 0, 1 and 2 in turn
      prev  = pick_reg(0, 15);
      prev2 = pick_reg(0, 15);
      prev3 = pick_reg(0, 15);
      for (int i = 0; i < N_CHAIN; i++)
        begin
          case (i % 3)
            0:       src2 = pick_reg(0, 31);
            1:       src2 = prev2;
            default: src2 = prev3;
          endcase
          dst = pick_reg(0, 15);
          issue_op(rand_int_op(), prev, src2, dst, 1'b0);
          prev3 = prev2;
          prev2 = prev;
          prev  = dst;
        end
      finish_test("chain");

      // Second multiply fills the gap before the dependent read
      for (int i = 0; i < N_MUL; i++)
        begin
          ra = pick_reg(0, 15);
          rb = pick_reg_except(ra, 0, 15);
          issue_op((i % 2) ? OP_MULHU : OP_MUL, pick_reg(16, 31), pick_reg(16, 31), ra, 1'b0);
          issue_op((i % 2) ? OP_MUL : OP_MULHU, pick_reg(16, 31), pick_reg(16, 31), rb, 1'b0);
          issue_op(rand_int_op(), ra, pick_reg_except(rb, 0, 31), pick_reg(0, 15), 1'b0);
        end
      finish_test("mul");

      for (int i = 0; i < N_INJ; i++)
        begin
          ra = pick_reg(0, 31);
          inject(ra, $urandom());
          issue_op(rand_int_op(), ra, pick_reg(0, 31), pick_reg(0, 31), 1'b0);
        end
      finish_test("inject");

      for (int i = 0; i < N_FLUSH; i++)
        begin
          ra = pick_reg(0, 31);
          rb = pick_reg(0, 31);
          rc = pick_reg(0, 31);
          re = pick_reg(0, 31);
          issue_op(rand_int_op(), pick_reg(0, 31), pick_reg(0, 31), ra, 1'b0);
          issue_op(OP_MUL, pick_reg(0, 31), pick_reg(0, 31), rb, 1'b1);
          issue_op(rand_int_op(), pick_reg(0, 31), pick_reg(0, 31), rc, 1'b1);
          flush = 1'b1;
          issue_op(rand_int_op(), pick_reg(0, 31), pick_reg(0, 31), re, 1'b1);
          flush = 1'b0;
          issue_op(rand_int_op(), rb, rc, pick_reg(0, 31), 1'b0);
          issue_op(rand_int_op(), ra, re, pick_reg(0, 31), 1'b0);
        end
      finish_test("flush");

      $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
               tests, tests_failed, checks, errors);
      if (errors == 0 && tests_failed == 0)
        $display("*** PASSED ***");
      else
        $display("*** FAILED ***");
      $finish;
    end

endmodule

/* verilog/calc_comp_pipe.sv */
//////////////////////////////////////////////////
// Completion pipe. Stage 0 is built from the
// reservation, later stages shift one per cycle
// and collect pipe results. The last stage is the
// register file write-back.
//////////////////////////////////////////////////

module calc_comp_pipe
  import calc_pkg::*;
  (input                                   clk_i
   , input                                 rst_i
   , input                                 flush_i

   , input                                 res_v_i
   , input                                 res_queue_v_i
   , input reg_addr_t                      res_rd_addr_i
   , input                                 res_rd_w_v_i
   , input data_t                          res_payload_i

   , input                                 int_v_i
   , input data_t                          int_data_i
   , input                                 mul_v_i
   , input data_t                          mul_data_i

   , output comp_pkt_t [COMP_STAGES-1:0]   stage_pkt_o
   , output data_t [COMP_STAGES-1:0]       fwd_data_o

   , output logic                          iwb_v_o
   , output reg_addr_t                     iwb_rd_addr_o
   , output data_t                         iwb_data_o
   );

  comp_pkt_t [COMP_STAGES-1:0] stage_q;
  comp_pkt_t [COMP_STAGES:1]   stage_n;
  comp_pkt_t [COMP_STAGES-1:1] stage_r;
  logic                        injection;
  logic                        kill_r;

  assign injection = res_v_i & ~res_queue_v_i;

  // The instruction dispatched during a flush sits in stage 0 one cycle later
  always_ff @(posedge clk_i)
    begin
      if (rst_i)
        kill_r <= 1'b0;
      else
        kill_r <= flush_i;
    end

  always_comb
    begin
      stage_q[0].w_v     = res_v_i & res_rd_w_v_i & ~kill_r;
      stage_q[0].rd_addr = res_rd_addr_i;
      stage_q[0].rd_data = injection ? res_payload_i : '0;
      for (int i = 1; i < COMP_STAGES; i++)
        stage_q[i] = stage_r[i];
    end

  // Single issue with fixed latencies, so at most one result per stage
  always_comb
    begin
      for (int i = 1; i <= COMP_STAGES; i++)
        stage_n[i] = stage_q[i-1];

      stage_n[1].rd_data |= int_v_i ? int_data_i : '0;
      stage_n[2].rd_data |= mul_v_i ? mul_data_i : '0;

      // Anything not yet at write-back dies on flush
      for (int i = 1; i < COMP_STAGES; i++)
        stage_n[i].w_v &= ~flush_i;
    end

  always_ff @(posedge clk_i)
    begin
      for (int i = 1; i < COMP_STAGES; i++)
        begin
          if (rst_i)
            stage_r[i].w_v <= 1'b0;
          else
            stage_r[i].w_v <= stage_n[i].w_v;
          stage_r[i].rd_addr <= stage_n[i].rd_addr;
          stage_r[i].rd_data <= stage_n[i].rd_data;
        end
    end

  // Forward next-state data so fresh results bypass without a bubble
  always_comb
    begin
      for (int i = 0; i < COMP_STAGES; i++)
        fwd_data_o[i] = stage_n[i+1].rd_data;
    end

  assign stage_pkt_o   = stage_q;
  assign iwb_v_o       = stage_r[COMP_STAGES-1].w_v;
  assign iwb_rd_addr_o = stage_r[COMP_STAGES-1].rd_addr;
  assign iwb_data_o    = stage_r[COMP_STAGES-1].rd_data;

endmodule

/* verilog/calc_issue.sv */
//////////////////////////////////////////////////
// Issue stage. Repairs stale dispatch operands by
// forwarding from the completion pipe, then holds
// the instruction in the reservation register
// that feeds both execution pipes.
//////////////////////////////////////////////////

module calc_issue
  import calc_pkg::*;
  (input                                 clk_i
   , input                               rst_i

   , input                               dispatch_v_i
   , input                               dispatch_queue_v_i
   , input op_e                          dispatch_op_i
   , input reg_addr_t                    rs1_addr_i
   , input reg_addr_t                    rs2_addr_i
   , input reg_addr_t                    rd_addr_i
   , input                               rd_w_v_i
   , input data_t                        rs1_data_i
   , input data_t                        rs2_data_i

   , input comp_pkt_t [COMP_STAGES-1:0]  stage_pkt_i
   , input data_t [COMP_STAGES-1:0]      fwd_data_i

   , output logic                        res_v_o
   , output logic                        res_queue_v_o
   , output op_e                         res_op_o
   , output data_t                       res_rs1_o
   , output data_t                       res_rs2_o
   , output reg_addr_t                   res_rd_addr_o
   , output logic                        res_rd_w_v_o
   );

  logic                   fwd_en;
  logic [COMP_STAGES-1:0] match_rs1;
  logic [COMP_STAGES-1:0] match_rs2;
  data_t                  rs1_bypass;
  data_t                  rs2_bypass;

  // Injections carry a payload in rs2 and never forward
  assign fwd_en = dispatch_v_i & dispatch_queue_v_i;

  always_comb
    begin
      for (int i = 0; i < COMP_STAGES; i++)
        begin
          match_rs1[i] = fwd_en & stage_pkt_i[i].w_v
                         & (stage_pkt_i[i].rd_addr == rs1_addr_i);
          match_rs2[i] = fwd_en & stage_pkt_i[i].w_v
                         & (stage_pkt_i[i].rd_addr == rs2_addr_i);
        end
    end

  // Walk oldest to youngest so the lowest matching stage wins
  always_comb
    begin
      rs1_bypass = rs1_data_i;
      rs2_bypass = rs2_data_i;
      for (int i = COMP_STAGES-1; i >= 0; i--)
        begin
          if (match_rs1[i])
            rs1_bypass = fwd_data_i[i];
          if (match_rs2[i])
            rs2_bypass = fwd_data_i[i];
        end
    end

  // Reservation register
  always_ff @(posedge clk_i)
    begin
      if (rst_i)
        begin
          res_v_o       <= 1'b0;
          res_queue_v_o <= 1'b0;
          res_rd_w_v_o  <= 1'b0;
        end
      else
        begin
          res_v_o       <= dispatch_v_i;
          res_queue_v_o <= dispatch_queue_v_i;
          res_rd_w_v_o  <= rd_w_v_i;
        end

      res_op_o      <= dispatch_op_i;
      res_rd_addr_o <= rd_addr_i;
      res_rs1_o     <= rs1_bypass;
      res_rs2_o     <= rs2_bypass;
    end

endmodule

/* verilog/calc_pipe_int.sv */
//////////////////////////////////////////////////
// Integer pipe. Evaluates the ALU operation held
// in the reservation register; the result is
// combinational and lands in completion stage 1.
//////////////////////////////////////////////////

module calc_pipe_int
  import calc_pkg::*;
  (input           res_v_i
   , input         res_queue_v_i
   , input op_e    res_op_i
   , input data_t  res_rs1_i
   , input data_t  res_rs2_i

   , output logic  v_o
   , output data_t data_o
   );

  localparam int SHAMT_WIDTH = $clog2(DATA_WIDTH);

  logic                   int_op;
  logic [SHAMT_WIDTH-1:0] shamt;
  logic                   lt_signed;

  assign int_op    = res_op_i inside {OP_ADD, OP_SUB, OP_AND, OP_OR,
                                      OP_XOR, OP_SLL, OP_SRL, OP_SLT};
  assign shamt     = res_rs2_i[SHAMT_WIDTH-1:0];
  assign lt_signed = $signed(res_rs1_i) < $signed(res_rs2_i);

  // Only real instructions are claimed here
  assign v_o = res_v_i & res_queue_v_i & int_op;

  always_comb
    begin
      case (res_op_i)
        OP_ADD:  data_o = res_rs1_i + res_rs2_i;
        OP_SUB:  data_o = res_rs1_i - res_rs2_i;
        OP_AND:  data_o = res_rs1_i & res_rs2_i;
        OP_OR:   data_o = res_rs1_i | res_rs2_i;
        OP_XOR:  data_o = res_rs1_i ^ res_rs2_i;
        OP_SLL:  data_o = res_rs1_i << shamt;
        OP_SRL:  data_o = res_rs1_i >> shamt;
        OP_SLT:  data_o = {{(DATA_WIDTH-1){1'b0}}, lt_signed};
        default: data_o = '0;
      endcase
    end

endmodule

/* verilog/calc_pipe_mul.sv */
//////////////////////////////////////////////////
// Two-stage multiply pipe. The first stage forms
// the full unsigned product, the second picks the
// low word for mul or the high word for mulhu.
//////////////////////////////////////////////////

module calc_pipe_mul
  import calc_pkg::*;
  (input           clk_i
   , input         rst_i

   , input         res_v_i
   , input         res_queue_v_i
   , input op_e    res_op_i
   , input data_t  res_rs1_i
   , input data_t  res_rs2_i
   , input         flush_i

   , output logic  v_o
   , output data_t data_o
   );

  logic                      claim;
  logic [2*DATA_WIDTH-1:0]   product;
  logic [2*DATA_WIDTH-1:0]   product_r;
  logic                      hi_r;
  logic                      v_r;

  assign claim = res_v_i & res_queue_v_i & (res_op_i inside {OP_MUL, OP_MULHU});

  // Zero extension keeps the product unsigned
  assign product = {{DATA_WIDTH{1'b0}}, res_rs1_i} * {{DATA_WIDTH{1'b0}}, res_rs2_i};

  always_ff @(posedge clk_i)
    begin
      if (rst_i | flush_i)
        v_r <= 1'b0;
      else
        v_r <= claim;

      if (claim)
        begin
          product_r <= product;
          hi_r      <= (res_op_i == OP_MULHU);
        end
    end

  assign v_o    = v_r;
  assign data_o = hi_r ? product_r[2*DATA_WIDTH-1:DATA_WIDTH] : product_r[DATA_WIDTH-1:0];

endmodule

/* verilog/calc_pkg.sv */
//////////////////////////////////////////////////
// Widths, opcodes and the completion stage packet
// shared by the execution back end. Modules pull
// these in with a wildcard import in their header.
//////////////////////////////////////////////////

package calc_pkg;

  localparam int DATA_WIDTH     = 32;
  localparam int REG_ADDR_WIDTH = 5;

  // Write-back leaves from the last stage
  localparam int COMP_STAGES    = 3;

  typedef logic [DATA_WIDTH-1:0]     data_t;
  typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

  // Shifts take the low 5 bits of rs2, slt compares signed
  typedef enum logic [3:0]
  {
    OP_ADD   = 4'h0,
    OP_SUB   = 4'h1,
    OP_AND   = 4'h2,
    OP_OR    = 4'h3,
    OP_XOR   = 4'h4,
    OP_SLL   = 4'h5,
    OP_SRL   = 4'h6,
    OP_SLT   = 4'h7,
    OP_MUL   = 4'h8,
    OP_MULHU = 4'h9
  } op_e;

  // One completion stage entry, 38 bits
  typedef struct packed
  {
    logic      w_v;
    reg_addr_t rd_addr;
    data_t     rd_data;
  } comp_pkt_t;

endpackage

/* verilog/calc_top.sv */
//////////////////////////////////////////////////
// Execution back end top level. Takes one dispatch
// per cycle and writes it back three cycles later.
// Injections write their rs2 payload to rd.
//////////////////////////////////////////////////

module calc_top
  import calc_pkg::*;
  (input               clk_i
   , input             rst_i

   , input             dispatch_v_i
   , input             dispatch_queue_v_i
   , input op_e        dispatch_op_i
   , input reg_addr_t  rs1_addr_i
   , input reg_addr_t  rs2_addr_i
   , input reg_addr_t  rd_addr_i
   , input             rd_w_v_i
   , input data_t      rs1_data_i
   , input data_t      rs2_data_i

   , input             flush_i

   , output logic      iwb_v_o
   , output reg_addr_t iwb_rd_addr_o
   , output data_t     iwb_data_o
   );

  logic                        res_v;
  logic                        res_queue_v;
  op_e                         res_op;
  data_t                       res_rs1;
  data_t                       res_rs2;
  reg_addr_t                   res_rd_addr;
  logic                        res_rd_w_v;

  logic                        int_v;
  data_t                       int_data;
  logic                        mul_v;
  data_t                       mul_data;

  comp_pkt_t [COMP_STAGES-1:0] stage_pkt;
  data_t [COMP_STAGES-1:0]     fwd_data;

  calc_issue i_issue
    (.clk_i              (clk_i)
     ,.rst_i             (rst_i)
     ,.dispatch_v_i      (dispatch_v_i)
     ,.dispatch_queue_v_i(dispatch_queue_v_i)
     ,.dispatch_op_i     (dispatch_op_i)
     ,.rs1_addr_i        (rs1_addr_i)
     ,.rs2_addr_i        (rs2_addr_i)
     ,.rd_addr_i         (rd_addr_i)
     ,.rd_w_v_i          (rd_w_v_i)
     ,.rs1_data_i        (rs1_data_i)
     ,.rs2_data_i        (rs2_data_i)
     ,.stage_pkt_i       (stage_pkt)
     ,.fwd_data_i        (fwd_data)
     ,.res_v_o           (res_v)
     ,.res_queue_v_o     (res_queue_v)
     ,.res_op_o          (res_op)
     ,.res_rs1_o         (res_rs1)
     ,.res_rs2_o         (res_rs2)
     ,.res_rd_addr_o     (res_rd_addr)
     ,.res_rd_w_v_o      (res_rd_w_v)
     );

  calc_pipe_int i_pipe_int
    (.res_v_i       (res_v)
     ,.res_queue_v_i(res_queue_v)
     ,.res_op_i     (res_op)
     ,.res_rs1_i    (res_rs1)
     ,.res_rs2_i    (res_rs2)
     ,.v_o          (int_v)
     ,.data_o       (int_data)
     );

  calc_pipe_mul i_pipe_mul
    (.clk_i         (clk_i)
     ,.rst_i        (rst_i)
     ,.res_v_i      (res_v)
     ,.res_queue_v_i(res_queue_v)
     ,.res_op_i     (res_op)
     ,.res_rs1_i    (res_rs1)
     ,.res_rs2_i    (res_rs2)
     ,.flush_i      (flush_i)
     ,.v_o          (mul_v)
     ,.data_o       (mul_data)
     );

  // The rs2 slot doubles as the injection payload
  calc_comp_pipe i_comp_pipe
    (.clk_i         (clk_i)
     ,.rst_i        (rst_i)
     ,.flush_i      (flush_i)
     ,.res_v_i      (res_v)
     ,.res_queue_v_i(res_queue_v)
     ,.res_rd_addr_i(res_rd_addr)
     ,.res_rd_w_v_i (res_rd_w_v)
     ,.res_payload_i(res_rs2)
     ,.int_v_i      (int_v)
     ,.int_data_i   (int_data)
     ,.mul_v_i      (mul_v)
     ,.mul_data_i   (mul_data)
     ,.stage_pkt_o  (stage_pkt)
     ,.fwd_data_o   (fwd_data)
     ,.iwb_v_o      (iwb_v_o)
     ,.iwb_rd_addr_o(iwb_rd_addr_o)
     ,.iwb_data_o   (iwb_data_o)
     );

endmodule

/* vlog.f */
+incdir+bench
verilog/calc_pkg.sv
verilog/calc_issue.sv
verilog/calc_pipe_int.sv
verilog/calc_pipe_mul.sv
verilog/calc_comp_pipe.sv
verilog/calc_top.sv
bench/tb_calc_top.sv
